// File: design/wb_xbar_pkg.sv
// Classic Wishbone only; CTI and BTE are carried but not interpreted, and the map is fixed here
package wb_xbar_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W  = DATA_W / 8;

	// Initiator and target counts
	localparam int N_INIT = 3;
	localparam int N_TGT  = 2;
	// External targets plus the decode-error target
	localparam int N_PORT = N_TGT + 1;

	localparam int INIT_ID_W = 2;
	localparam int TGT_ID_W  = 2;

	// Address map, limits are inclusive
	localparam logic [ADDR_W-1:0] TGT0_BASE  = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] TGT0_LIMIT = 32'h0000_0FFF;
	localparam logic [ADDR_W-1:0] TGT1_BASE  = 32'h1000_0000;
	localparam logic [ADDR_W-1:0] TGT1_LIMIT = 32'h1000_0FFF;

	// Port index of the internal error target
	localparam logic [TGT_ID_W-1:0] ERR_TGT = 2'd2;
	// Tracker value when no target is selected
	localparam logic [TGT_ID_W-1:0] NO_TGT  = 2'd3;

	// Request from initiator toward a target
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [SEL_W-1:0]  sel;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat;
		logic [2:0]        cti;
		logic [1:0]        bte;
	} wb_req_t;

	// Response from target back to initiator
	typedef struct packed {
		logic              ack;
		logic              err;
		logic [DATA_W-1:0] dat;
	} wb_rsp_t;

	// Owner of a target port, as seen by the mux
	typedef struct packed {
		logic                 valid;
		logic [INIT_ID_W-1:0] id;
	} init_sel_t;

	// Answering target of an initiator, as seen by the mux
	typedef struct packed {
		logic                valid;
		logic [TGT_ID_W-1:0] id;
	} tgt_sel_t;

endpackage

// File: design/wb_xbar_ctrl.sv
// Initiators must hold cyc, stb and the request stable until ack or err; dropping cyc early is not tracked
`timescale 1ns/1ps

module wb_xbar_ctrl import wb_xbar_pkg::*; (
	input  logic                 clk,
	input  logic                 rstn,
	input  wb_req_t              init_req_i [N_INIT],
	input  wb_rsp_t              init_rsp_i [N_INIT],
	input  logic [N_PORT-1:0]    gnt_i,
	input  logic [INIT_ID_W-1:0] gnt_id_i [N_PORT],
	output logic [N_INIT-1:0]    arb_req_o [N_PORT],
	output init_sel_t            port_sel_o [N_PORT],
	output tgt_sel_t             init_sel_o [N_INIT]
);

	// Per-initiator tracker, idle when busy_q is low
	logic [N_INIT-1:0]   busy_q;
	logic [TGT_ID_W-1:0] tgt_q [N_INIT];

	// Map an address to a port, the error target catches everything else
	function automatic logic [TGT_ID_W-1:0] decode_tgt(input logic [ADDR_W-1:0] adr);
		logic [TGT_ID_W-1:0] tgt;
		tgt = ERR_TGT;
		if (adr >= TGT0_BASE && adr <= TGT0_LIMIT) begin
			tgt = TGT_ID_W'(0);
		end else if (adr >= TGT1_BASE && adr <= TGT1_LIMIT) begin
			tgt = TGT_ID_W'(1);
		end
		return tgt;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_q <= '0;
			for (int i = 0; i < N_INIT; i++) begin
				tgt_q[i] <= NO_TGT;
			end
		end else begin
			for (int i = 0; i < N_INIT; i++) begin
				if (!busy_q[i]) begin
					// Decode is registered, so the route starts a cycle later
					if (init_req_i[i].cyc && init_req_i[i].stb) begin
						busy_q[i] <= 1'b1;
						tgt_q[i]  <= decode_tgt(init_req_i[i].adr);
					end
				end else if (init_rsp_i[i].ack || init_rsp_i[i].err) begin
					busy_q[i] <= 1'b0;
					tgt_q[i]  <= NO_TGT;
				end
			end
		end
	end

	// Request vector of each port's arbiter
	always_comb begin
		for (int p = 0; p < N_PORT; p++) begin
			for (int i = 0; i < N_INIT; i++) begin
				arb_req_o[p][i] = busy_q[i] && (tgt_q[i] == TGT_ID_W'(p));
			end
		end
	end

	// Port owner is valid only while the granted initiator is busy on this very port
	always_comb begin
		for (int p = 0; p < N_PORT; p++) begin
			port_sel_o[p].id    = gnt_id_i[p];
			port_sel_o[p].valid = 1'b0;
			if (gnt_i[p]) begin
				port_sel_o[p].valid = busy_q[gnt_id_i[p]] &&
					(tgt_q[gnt_id_i[p]] == TGT_ID_W'(p));
			end
		end
	end

	// Response path, the same ownership check seen from the initiator side
	always_comb begin
		for (int i = 0; i < N_INIT; i++) begin
			init_sel_o[i].id    = tgt_q[i];
			init_sel_o[i].valid = 1'b0;
			if (busy_q[i]) begin
				init_sel_o[i].valid = gnt_i[tgt_q[i]] &&
					(gnt_id_i[tgt_q[i]] == INIT_ID_W'(i));
			end
		end
	end

endmodule

// File: design/wb_rr_arbiter.sv
// Grant is registered and held until the owner's request drops, with one idle cycle between owners
`timescale 1ns/1ps

module wb_rr_arbiter import wb_xbar_pkg::*; (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic [N_INIT-1:0]    req_i,
	output logic                 gnt_o,
	output logic [INIT_ID_W-1:0] gnt_id_o
);

	logic                 gnt_q;
	logic [INIT_ID_W-1:0] gnt_id_q;
	// One-hot record of the last grant
	logic [N_INIT-1:0]    last_q;

	logic [N_INIT-1:0]    above_mask;
	logic [N_INIT-1:0]    pick_req;
	logic [N_INIT-1:0]    pick_oh;
	logic [INIT_ID_W-1:0] pick_id;

	// Pick the first requester above the last grant, else the lowest one
	always_comb begin
		logic seen;
		logic found;
		seen = 1'b0;
		for (int i = 0; i < N_INIT; i++) begin
			above_mask[i] = seen;
			seen = seen | last_q[i];
		end
		pick_req = ((req_i & above_mask) != '0) ? (req_i & above_mask) : req_i;
		found    = 1'b0;
		pick_oh  = '0;
		pick_id  = '0;
		for (int i = 0; i < N_INIT; i++) begin
			if (pick_req[i] && !found) begin
				found      = 1'b1;
				pick_oh[i] = 1'b1;
				pick_id    = INIT_ID_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q    <= 1'b0;
			gnt_id_q <= '0;
			last_q   <= '0;
		end else if (!gnt_q) begin
			if (req_i != '0) begin
				gnt_q    <= 1'b1;
				gnt_id_q <= pick_id;
				last_q   <= pick_oh;
			end
		end else if (!req_i[gnt_id_q]) begin
			// Owner finished, free the port
			gnt_q <= 1'b0;
		end
	end

	assign gnt_o    = gnt_q;
	assign gnt_id_o = gnt_id_q;

endmodule

// File: design/wb_xbar_mux.sv
// Purely combinational steering; selects must come from the control, which guarantees one owner per port
`timescale 1ns/1ps

module wb_xbar_mux import wb_xbar_pkg::*; (
	input  wb_req_t   init_req_i [N_INIT],
	input  wb_rsp_t   tgt_rsp_i  [N_PORT],
	input  init_sel_t port_sel_i [N_PORT],
	input  tgt_sel_t  init_sel_i [N_INIT],
	output wb_req_t   port_req_o [N_PORT],
	output wb_rsp_t   init_rsp_o [N_INIT]
);

	// Request side, each port carries its owner's request or nothing
	always_comb begin
		for (int p = 0; p < N_PORT; p++) begin
			port_req_o[p] = '0;
			if (port_sel_i[p].valid) begin
				port_req_o[p] = init_req_i[port_sel_i[p].id];
			end
		end
	end

	// Response side, ack, err and read data go back to the owner only
	always_comb begin
		for (int i = 0; i < N_INIT; i++) begin
			init_rsp_o[i] = '0;
			if (init_sel_i[i].valid) begin
				init_rsp_o[i] = tgt_rsp_i[init_sel_i[i].id];
			end
		end
	end

endmodule

// File: design/wb_decode_err_target.sv
// Answers every strobe with a one-cycle err and zero data; never acks
`timescale 1ns/1ps

module wb_decode_err_target import wb_xbar_pkg::*; (
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic err_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			// Skip the cycle after a pulse, the strobe is still up then
			err_q <= req_i.cyc && req_i.stb && !err_q;
		end
	end

	assign rsp_o.ack = 1'b0;
	assign rsp_o.err = err_q;
	assign rsp_o.dat = '0;

endmodule

// File: design/wb_xbar_3x2.sv
// Three classic initiators onto two targets; a request needs at least two cycles to reach its target
`timescale 1ns/1ps

module wb_xbar_3x2 import wb_xbar_pkg::*; (
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t init_req_i [N_INIT],
	output wb_rsp_t init_rsp_o [N_INIT],
	output wb_req_t tgt_req_o  [N_TGT],
	input  wb_rsp_t tgt_rsp_i  [N_TGT]
);

	logic [N_INIT-1:0]    arb_req [N_PORT];
	logic [N_PORT-1:0]    gnt;
	logic [INIT_ID_W-1:0] gnt_id [N_PORT];
	init_sel_t            port_sel [N_PORT];
	tgt_sel_t             init_sel [N_INIT];
	wb_req_t              port_req [N_PORT];
	wb_rsp_t              port_rsp [N_PORT];

	wb_xbar_ctrl ctrl_i (
		.clk        (clk),
		.rstn       (rstn),
		.init_req_i (init_req_i),
		.init_rsp_i (init_rsp_o),
		.gnt_i      (gnt),
		.gnt_id_i   (gnt_id),
		.arb_req_o  (arb_req),
		.port_sel_o (port_sel),
		.init_sel_o (init_sel)
	);

	// One arbiter per port, the error target included
	for (genvar p = 0; p < N_PORT; p++) begin : g_arb
		wb_rr_arbiter arb_i (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (arb_req[p]),
			.gnt_o    (gnt[p]),
			.gnt_id_o (gnt_id[p])
		);
	end

	wb_xbar_mux mux_i (
		.init_req_i (init_req_i),
		.tgt_rsp_i  (port_rsp),
		.port_sel_i (port_sel),
		.init_sel_i (init_sel),
		.port_req_o (port_req),
		.init_rsp_o (init_rsp_o)
	);

	// External ports take the low indices
	for (genvar t = 0; t < N_TGT; t++) begin : g_tgt
		assign tgt_req_o[t] = port_req[t];
		assign port_rsp[t]  = tgt_rsp_i[t];
	end

	wb_decode_err_target err_tgt_i (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (port_req[ERR_TGT]),
		.rsp_o (port_rsp[ERR_TGT])
	);

endmodule

// File: test/wb_mem_model.sv
// Simulation target of 1024 words at adr[11:2], upper address bits ignored, read data is zero on writes
`timescale 1ns/1ps

module wb_mem_model import wb_xbar_pkg::*; (
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic [DATA_W-1:0] mem [1024];
	logic              ack_q;
	logic [DATA_W-1:0] dat_q;
	logic [9:0]        idx;
	// Every strobed access in arrival order, read by the testbench
	wb_req_t           log_q [$];

	assign idx = req_i.adr[11:2];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
			dat_q <= '0;
			// Fill pattern changes with every index bit
			for (int i = 0; i < 1024; i++) begin
				mem[i] <= 32'h5a00_0000 ^ (DATA_W'(i) << 2) ^ (DATA_W'(i) << 16);
			end
		end else if (req_i.cyc && req_i.stb && !ack_q) begin
			ack_q <= 1'b1;
			dat_q <= req_i.we ? '0 : mem[idx];
			if (req_i.we) begin
				for (int b = 0; b < SEL_W; b++) begin
					if (req_i.sel[b]) begin
						mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
					end
				end
			end
			log_q.push_back(req_i);
		end else begin
			// The strobe may still be up in the cycle after an ack
			ack_q <= 1'b0;
			dat_q <= '0;
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;
	assign rsp_o.dat = dat_q;

endmodule

// File: test/wb_xbar_tb.sv
// Rows of one group must use distinct initiators listed in rising order, which is also the grant order
`timescale 1ns/1ps

module wb_xbar_tb import wb_xbar_pkg::*; ();

	localparam int N_ROWS   = 21;
	localparam int N_GROUPS = 15;
	// Decode, grant and the target's registered answer
	localparam int SOLO_LAT = 3;

	typedef struct packed {
		logic [7:0]           grp;
		logic [INIT_ID_W-1:0] init;
		logic                 we;
		logic [ADDR_W-1:0]    adr;
		logic [DATA_W-1:0]    dat;
		logic [SEL_W-1:0]     sel;
		logic                 is_err;
		logic                 solo;
		logic [DATA_W-1:0]    exp_dat;
	} row_t;

	logic    clk;
	logic    rstn;
	wb_req_t init_req [N_INIT];
	wb_rsp_t init_rsp [N_INIT];
	wb_req_t tgt_req  [N_TGT];
	wb_rsp_t tgt_rsp  [N_TGT];

	row_t              rows [N_ROWS];
	int                n_rows;
	// Expected memory contents by word address
	logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
	integer            seed;
	int                value_errs;
	int                other_errs;
	int                rsp_seen [N_INIT];
	int                rsp_exp  [N_INIT];
	logic              ext_quiet;

	wb_xbar_3x2 dut_i (
		.clk        (clk),
		.rstn       (rstn),
		.init_req_i (init_req),
		.init_rsp_o (init_rsp),
		.tgt_req_o  (tgt_req),
		.tgt_rsp_i  (tgt_rsp)
	);

	wb_mem_model mem0_i (.clk(clk), .rstn(rstn), .req_i(tgt_req[0]), .rsp_o(tgt_rsp[0]));
	wb_mem_model mem1_i (.clk(clk), .rstn(rstn), .req_i(tgt_req[1]), .rsp_o(tgt_rsp[1]));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		repeat (N_ROWS * 40) @(posedge clk);
		$display("Timeout after %0d cycles, the test sequence did not complete", N_ROWS * 40);
		$display("STATUS: FAIL");
		$finish;
	end

	// Window of an address per the address map, N_TGT stands for the error target
	function automatic int window_of(input logic [ADDR_W-1:0] adr);
		if (adr >= TGT0_BASE && adr <= TGT0_LIMIT) begin
			return 0;
		end
		if (adr >= TGT1_BASE && adr <= TGT1_LIMIT) begin
			return 1;
		end
		return N_TGT;
	endfunction

	function automatic logic [DATA_W-1:0] merge_word(input logic [DATA_W-1:0] old_w,
			input logic [DATA_W-1:0] new_w, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] w;
		w = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				w[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return w;
	endfunction

	task automatic check_rsp(input string name, input wb_rsp_t got, input wb_rsp_t exp);
		if (got.ack !== exp.ack || got.err !== exp.err || got.dat !== exp.dat) begin
			value_errs++;
			$display("FAILED %s: ack/err/dat = %h/%h/%h, expected %h/%h/%h",
				name, got.ack, got.err, got.dat, exp.ack, exp.err, exp.dat);
		end
	endtask

	task automatic check_tgt_req(input string name, input wb_req_t got, input wb_req_t exp);
		if (got.cyc !== exp.cyc || got.stb !== exp.stb || got.we !== exp.we ||
				got.sel !== exp.sel || got.adr !== exp.adr) begin
			value_errs++;
			$display("FAILED %s: cyc/stb/we/sel/adr = %h/%h/%h/%h/%h, expected %h/%h/%h/%h/%h",
				name, got.cyc, got.stb, got.we, got.sel, got.adr,
				exp.cyc, exp.stb, exp.we, exp.sel, exp.adr);
		end
	endtask

	task automatic add_row(input int g, input int i, input logic we,
			input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
			input logic [SEL_W-1:0] sel, input logic solo);
		row_t              row;
		logic [ADDR_W-1:0] key;
		row = '0;
		key = adr & ~ADDR_W'(3);
		row.grp    = 8'(g);
		row.init   = INIT_ID_W'(i);
		row.we     = we;
		row.adr    = adr;
		row.dat    = dat;
		row.sel    = sel;
		row.solo   = solo;
		row.is_err = (window_of(adr) == N_TGT);
		// Writes and errors answer with zero data
		if (!row.is_err && we) begin
			shadow[key] = merge_word(shadow.exists(key) ? shadow[key] : '0, dat, sel);
		end else if (!row.is_err) begin
			row.exp_dat = shadow[key];
		end
		rows[n_rows] = row;
		n_rows++;
	endtask

	task automatic build_table();
		logic [ADDR_W-1:0] rnd_adr [N_INIT];
		logic [ADDR_W-1:0] a0;
		logic [ADDR_W-1:0] a1;
		// Write then read window 0 from each initiator in turn
		add_row(0, 0, 1'b1, 32'h0000_0100, 32'h1111_2222, 4'hf, 1'b1);
		add_row(1, 0, 1'b0, 32'h0000_0100, 32'h0, 4'hf, 1'b1);
		add_row(2, 1, 1'b1, 32'h0000_0204, 32'h3333_4444, 4'hf, 1'b1);
		add_row(3, 1, 1'b0, 32'h0000_0204, 32'h0, 4'hf, 1'b1);
		add_row(4, 2, 1'b1, 32'h0000_0ffc, 32'h5555_6666, 4'hf, 1'b1);
		add_row(5, 2, 1'b0, 32'h0000_0ffc, 32'h0, 4'hf, 1'b1);
		// Byte lanes merge into the old word in window 1
		add_row(6, 1, 1'b1, 32'h1000_0010, 32'haabb_ccdd, 4'hf, 1'b1);
		add_row(7, 2, 1'b1, 32'h1000_0010, 32'h1122_3344, 4'b0101, 1'b1);
		add_row(8, 0, 1'b0, 32'h1000_0010, 32'h0, 4'hf, 1'b1);
		// Outside the map, just above window 0 too
		add_row(9, 2, 1'b1, 32'h2000_0000, 32'hdead_beef, 4'hf, 1'b1);
		add_row(10, 0, 1'b0, 32'h0000_1000, 32'h0, 4'hf, 1'b1);
		// All three on window 0 at once
		for (int i = 0; i < N_INIT; i++) begin
			rnd_adr[i] = TGT0_BASE | (ADDR_W'($random(seed)) & 32'h0000_0ff0) | ADDR_W'(i * 4);
			add_row(11, i, 1'b1, rnd_adr[i], $random(seed), 4'hf, 1'b0);
		end
		for (int i = 0; i < N_INIT; i++) begin
			add_row(12, i, 1'b0, rnd_adr[i], 32'h0, 4'hf, 1'b0);
		end
		// Both windows in parallel, neither may wait
		a0 = TGT0_BASE | (ADDR_W'($random(seed)) & 32'h0000_0ffc);
		a1 = TGT1_BASE | (ADDR_W'($random(seed)) & 32'h0000_0ffc);
		add_row(13, 0, 1'b1, a0, $random(seed), 4'hf, 1'b1);
		add_row(13, 1, 1'b1, a1, $random(seed), 4'hf, 1'b1);
		add_row(14, 0, 1'b0, a0, 32'h0, 4'hf, 1'b1);
		add_row(14, 1, 1'b0, a1, 32'h0, 4'hf, 1'b1);
	endtask

	// Starts on a falling edge and holds the request until ack or err
	task automatic drive_row(input int r);
		row_t    row;
		wb_req_t req;
		wb_rsp_t got;
		wb_rsp_t exp;
		int      lat;
		row = rows[r];
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = row.we;
		req.sel = row.sel;
		req.adr = row.adr;
		req.dat = row.dat;
		init_req[row.init] = req;
		lat = 0;
		got = '0;
		while (!(got.ack || got.err)) begin
			@(negedge clk);
			lat++;
			got = init_rsp[row.init];
		end
		init_req[row.init] = '0;
		rsp_exp[row.init]++;
		exp.ack = !row.is_err;
		exp.err = row.is_err;
		exp.dat = row.exp_dat;
		check_rsp($sformatf("init_rsp_o[%0d] row %0d", row.init, r), got, exp);
		if (row.solo && lat > SOLO_LAT) begin
			other_errs++;
			$display("Initiator %0d waited %0d cycles in row %0d, no more than %0d expected",
				row.init, lat, r, SOLO_LAT);
		end
	endtask

	// Target accesses of a group must appear in table order
	task automatic check_log(input int t, input int g, input int base);
		wb_req_t seen [$];
		wb_req_t exp;
		int      k;
		if (t == 0) begin
			seen = mem0_i.log_q;
		end else begin
			seen = mem1_i.log_q;
		end
		k = base;
		for (int r = 0; r < N_ROWS; r++) begin
			if (rows[r].grp == 8'(g) && window_of(rows[r].adr) == t) begin
				if (k >= seen.size()) begin
					other_errs++;
					$display("Target %0d never saw the access of initiator %0d in group %0d",
						t, rows[r].init, g);
				end else begin
					exp = '0;
					exp.cyc = 1'b1;
					exp.stb = 1'b1;
					exp.we  = rows[r].we;
					exp.sel = rows[r].sel;
					exp.adr = rows[r].adr;
					check_tgt_req($sformatf("tgt_req_o[%0d] access %0d", t, k), seen[k], exp);
				end
				k++;
			end
		end
		if (seen.size() > k) begin
			other_errs++;
			$display("Target %0d served %0d extra accesses in group %0d", t, seen.size() - k, g);
		end
	endtask

	task automatic run_group(input int g);
		int   base0;
		int   base1;
		logic quiet;
		base0 = mem0_i.log_q.size();
		base1 = mem1_i.log_q.size();
		quiet = 1'b1;
		for (int r = 0; r < N_ROWS; r++) begin
			if (rows[r].grp == 8'(g) && !rows[r].is_err) begin
				quiet = 1'b0;
			end
		end
		ext_quiet = quiet;
		for (int r = 0; r < N_ROWS; r++) begin
			int rr = r;
			if (rows[rr].grp == 8'(g)) begin
				fork
					drive_row(rr);
				join_none
			end
		end
		wait fork;
		repeat (2) @(negedge clk);
		ext_quiet = 1'b0;
		check_log(0, g, base0);
		check_log(1, g, base1);
		for (int i = 0; i < N_INIT; i++) begin
			if (rsp_seen[i] != rsp_exp[i]) begin
				other_errs++;
				$display("Initiator %0d got %0d responses by group %0d, %0d expected",
					i, rsp_seen[i], g, rsp_exp[i]);
				rsp_seen[i] = rsp_exp[i];
			end
		end
	endtask

	// Counts every answer and watches the external ports during decode errors
	always @(negedge clk) begin
		for (int i = 0; i < N_INIT; i++) begin
			if (rstn && (init_rsp[i].ack || init_rsp[i].err)) begin
				rsp_seen[i]++;
			end
		end
		for (int t = 0; t < N_TGT; t++) begin
			if (ext_quiet && tgt_req[t].stb) begin
				other_errs++;
				$display("Target %0d saw a strobe during an access outside the map", t);
			end
		end
	end

	initial begin
		value_errs = 0;
		other_errs = 0;
		n_rows     = 0;
		ext_quiet  = 1'b0;
		seed       = 32'hc1289cb8;
		rstn       = 1'b0;
		for (int i = 0; i < N_INIT; i++) begin
			init_req[i] = '0;
			rsp_seen[i] = 0;
			rsp_exp[i]  = 0;
		end
		build_table();
		repeat (3) @(negedge clk);
		for (int t = 0; t < N_TGT; t++) begin
			check_tgt_req($sformatf("tgt_req_o[%0d] in reset", t), tgt_req[t], '0);
		end
		for (int i = 0; i < N_INIT; i++) begin
			check_rsp($sformatf("init_rsp_o[%0d] in reset", i), init_rsp[i], '0);
		end
		rstn = 1'b1;
		@(negedge clk);
		for (int g = 0; g < N_GROUPS; g++) begin
			run_group(g);
		end
		$display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: project.f
design/wb_xbar_pkg.sv
design/wb_xbar_ctrl.sv
design/wb_rr_arbiter.sv
design/wb_xbar_mux.sv
design/wb_decode_err_target.sv
design/wb_xbar_3x2.sv
test/wb_mem_model.sv
test/wb_xbar_tb.sv

// File: Bender.yml
package:
  name: wb_xbar

sources:
  - files:
      - design/wb_xbar_pkg.sv
      - design/wb_xbar_ctrl.sv
      - design/wb_rr_arbiter.sv
      - design/wb_xbar_mux.sv
      - design/wb_decode_err_target.sv
      - design/wb_xbar_3x2.sv
  - target: test
    files:
      - test/wb_mem_model.sv
      - test/wb_xbar_tb.sv
